// ==== project.f ====
rtl/opm_pkg.sv
rtl/opm_mmr.sv
rtl/opm_timers.sv
rtl/opm_noise.sv
rtl/opm_mixer.sv
rtl/opm_top.sv
verif/opm_chk.sv
verif/opm_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module opm_tb -o opm_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/opm_sim > sim.log 2>&1 || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== verif/opm_tb.sv ====
`timescale 1ns/1ns

module opm_tb import opm_pkg::*; ();

    logic      zero = 1'b0;
    logic      cen  = 1'b0;
    logic      reset;
    logic      cs_n;
    logic      wr_n;
    logic      a0;
    bus_byte_t din;
    bus_byte_t dout;
    logic      ct1;
    logic      ct2;
    logic      irq_n;
    logic      sample;
    sample_t   left;
    sample_t   right;
    dac_t      dac_left;
    dac_t      dac_right;

    int      errors;
    int      tests;
    int      failed_tests;
    int      dac_errors = 0;
    int      frames     = 0;    // sample strobes seen
    logic    sample_d   = 1'b0;
    sample_t left_q[$];
    sample_t right_q[$];

    opm_top i_opm_top (
        .zero      ( zero      ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .cs_n      ( cs_n      ),
        .wr_n      ( wr_n      ),
        .a0        ( a0        ),
        .din       ( din       ),
        .dout      ( dout      ),
        .ct1       ( ct1       ),
        .ct2       ( ct2       ),
        .irq_n     ( irq_n     ),
        .sample    ( sample    ),
        .left      ( left      ),
        .right     ( right     ),
        .dac_left  ( dac_left  ),
        .dac_right ( dac_right )
    );

    always #2 zero = ~zero;

    always @(negedge zero) cen <= ~cen;    // one tick every other clock

    always @(posedge sample) frames <= frames + 1;

    // expected LFSR bit0 after a number of steps from the seed
    function automatic logic noise_ref(input int steps);
        logic [16:0] state;
        state = NOISE_SEED;
        for (int i = 0; i < steps; i++)
            state = {state[0] ^ state[3], state[16:1]};    // shift right, feedback 0 ^ 3
        return state[0];
    endfunction

    // captures every new pair and checks the offset binary words
    always @(negedge zero) begin
        sample_d <= sample;
        if (!reset && sample && !sample_d) begin
            left_q.push_back(left);
            right_q.push_back(right);
            if (dac_left !== (dac_t'(left) ^ 16'h8000) ||
                dac_right !== (dac_t'(right) ^ 16'h8000)) begin
                $display("FAILED at %0t ns: dac %h/%h for samples %h/%h",
                         $time, dac_left, dac_right, left, right);
                dac_errors <= dac_errors + 1;
            end
        end
    end

    task automatic report_wrong(input string what);
        $display("FAILED at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic bus_cycle(input logic addr_bit, input bus_byte_t data);
        cs_n = 1'b0;
        wr_n = 1'b0;
        a0   = addr_bit;
        din  = data;
        repeat (2) @(negedge zero);    // covers exactly one cen tick
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_status(input int bit_idx, input logic value,
                               input int max_clocks, input string what);
        int waited;
        waited = 0;
        while (dout[bit_idx] !== value && waited < max_clocks) begin
            @(negedge zero);
            waited++;
        end
        if (dout[bit_idx] !== value) begin
            $display("timeout: %s did not happen within %0d clocks", what, max_clocks);
            errors++;
        end
    endtask

    task automatic write_reg(input bus_byte_t addr, input bus_byte_t data);
        wait_status(7, 1'b0, 200, "busy clearing");
        bus_cycle(1'b0, addr);
        bus_cycle(1'b1, data);
    endtask

    task automatic wait_captures(input int count, input int max_clocks);
        int waited;
        waited = 0;
        while (left_q.size() < count && waited < max_clocks) begin
            @(negedge zero);
            waited++;
        end
        if (left_q.size() < count) begin
            $display("timeout: only %0d of %0d sample strobes arrived", left_q.size(), count);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: fail, %0d errors", tests, name, errors - err_before);
        end
    endtask

    initial begin
        #500_000;
        $display("watchdog: simulation ran far longer than expected");
        $display("Errors found");
        $finish;
    end

    initial begin
        int        err_before;
        int        f0;
        int        base;
        int        first;
        logic      ok;
        logic      matched;
        bus_byte_t level;
        sample_t   mag;
        sample_t   v;

        reset        = 1'b1;
        cs_n         = 1'b1;
        wr_n         = 1'b1;
        a0           = 1'b0;
        din          = '0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        repeat (8) @(negedge zero);

        // reset and status
        err_before = errors;
        if (dout !== 8'h00) report_wrong($sformatf("status %h in reset, expected 00", dout));
        if (irq_n !== 1'b1) report_wrong("irq_n low in reset");
        if ({ct1, ct2} !== 2'b00) report_wrong("ct pins set in reset");
        if (sample !== 1'b0 || left !== '0 || right !== '0) report_wrong("outputs not cleared");
        reset = 1'b0;
        @(negedge zero);
        write_reg(ADDR_CT, 8'hC0);
        if (dout[7] !== 1'b1) report_wrong("busy not set after a data write");
        wait_status(7, 1'b0, 200, "busy falling");
        if ({ct1, ct2} !== 2'b11) report_wrong("ct1/ct2 not both set");
        write_reg(ADDR_CT, 8'h40);
        wait_status(7, 1'b0, 200, "busy falling");
        if ({ct1, ct2} !== 2'b10) report_wrong("ct1/ct2 not 1/0");
        finish_test("reset and status", err_before);

        // timer A, 1016 gives 8 frames
        err_before = errors;
        write_reg(ADDR_TA_HI, 8'hFE);
        write_reg(ADDR_TA_LO, 8'h00);
        write_reg(ADDR_TIMER_CTRL, 8'h01);
        wait_status(0, 1'b1, 12 * 2 * SLOTS, "first timer A overflow");
        if (irq_n !== 1'b1) report_wrong("irq_n low with irq enable A clear");
        write_reg(ADDR_TIMER_CTRL, 8'h05);
        if (irq_n !== 1'b0) report_wrong("irq_n high with flag A enabled");
        write_reg(ADDR_TIMER_CTRL, 8'h15);
        wait_status(0, 1'b0, 8, "flag A clearing");
        if (irq_n !== 1'b1) report_wrong("irq_n low after flag A cleared");
        wait_status(0, 1'b1, 12 * 2 * SLOTS, "timer A overflow");
        f0 = frames;
        write_reg(ADDR_TIMER_CTRL, 8'h11);
        wait_status(0, 1'b0, 8, "flag A clearing");
        wait_status(0, 1'b1, 12 * 2 * SLOTS, "next timer A overflow");
        if (frames - f0 != 8) report_wrong($sformatf("timer A period %0d frames", frames - f0));
        write_reg(ADDR_TIMER_CTRL, 8'h10);    // stop A, drop its flag
        finish_test("timer A", err_before);

        // timer B at 254, two steps of 16 frames, and clearing only its flag
        err_before = errors;
        write_reg(ADDR_TB, 8'hFE);
        write_reg(ADDR_TIMER_CTRL, 8'h0B);    // run both, irq on B
        f0 = frames;
        wait_status(1, 1'b1, 34 * 2 * SLOTS, "timer B overflow");
        if (frames - f0 > 32 || frames - f0 < 17)
            report_wrong($sformatf("flag B after %0d frames", frames - f0));
        wait_status(0, 1'b1, 10 * 2 * SLOTS, "timer A overflow");
        if (irq_n !== 1'b0) report_wrong("irq_n high with flag B enabled");
        write_reg(ADDR_TIMER_CTRL, 8'h2B);
        wait_status(1, 1'b0, 8, "flag B clearing");
        if (dout[0] !== 1'b1) report_wrong("clearing flag B also dropped flag A");
        if (irq_n !== 1'b1) report_wrong("irq_n low after flag B cleared");
        write_reg(ADDR_TIMER_CTRL, 8'h30);
        wait_status(0, 1'b0, 8, "flag A clearing");
        finish_test("timer B and flag clear", err_before);

        // noise on the left side only
        err_before = errors;
        level = 8'h40;
        mag   = sample_t'(level * 64);
        base  = left_q.size();
        write_reg(ADDR_LEVEL, level);
        write_reg(ADDR_PAN, 8'h40);
        write_reg(ADDR_NOISE, 8'h9F);         // ne, nfrq 31
        wait_captures(base + 50, 50 * 2 * SLOTS + 200);
        first = -1;
        for (int i = base; i < left_q.size(); i++)
            if (first < 0 && left_q[i] != '0) first = i;
        if (first < 0 || first + 40 > left_q.size()) begin
            report_wrong("too few nonzero noise samples");
        end else begin
            for (int i = first; i < first + 40; i++)
                if (left_q[i] != mag && left_q[i] != -mag)
                    report_wrong($sformatf("left %0d is %0d, not +/-%0d", i, left_q[i], mag));
            matched = 1'b0;
            for (int off = 0; off <= 2; off++) begin
                ok = 1'b1;
                for (int i = 0; i < 40; i++) begin
                    v = left_q[first + i];
                    if (v[15] == noise_ref(off + i)) ok = 1'b0;    // negative means bit 0
                end
                if (ok) matched = 1'b1;
            end
            if (!matched) report_wrong("noise signs do not follow the LFSR sequence");
        end
        finish_test("noise sequence", err_before);

        // pan and dac words
        err_before = errors;
        for (int i = base; i < right_q.size(); i++)
            if (right_q[i] != '0) report_wrong($sformatf("right %0d is %0d", i, right_q[i]));
        if (dac_right !== 16'h8000) report_wrong($sformatf("dac_right %h", dac_right));
        if (dac_left !== (dac_t'(left) ^ 16'h8000)) report_wrong("dac_left not offset binary");
        if (dac_errors != 0) report_wrong($sformatf("%0d strobes had wrong dac words", dac_errors));
        finish_test("pan and dac", err_before);

        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && dac_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verif/opm_chk.sv ====
`timescale 1ns/1ns

module opm_chk import opm_pkg::*; (
    input logic       zero,
    input logic       reset,
    input logic       cen,
    input logic       busy,
    input logic       flag_a,
    input logic       flag_b,
    input logic       irq_n,
    input timer_cfg_t timer_cfg,
    input logic       sample,
    input sample_t    left,
    input sample_t    right
);

    int busy_len;    // ticks spent busy so far

    always_ff @(posedge zero) begin
        if (reset)
            busy_len <= 0;
        else if (cen)
            busy_len <= busy ? busy_len + 1 : 0;
    end

    // a clear of every enabled flag releases irq_n
    irq_released_by_clear: assert property (@(posedge zero) disable iff (reset)
        cen && (timer_cfg.clr_a || timer_cfg.clr_b) &&
        (timer_cfg.clr_a || !timer_cfg.irq_en_a) &&
        (timer_cfg.clr_b || !timer_cfg.irq_en_b) |=> irq_n)
        else $error("irq_n still low after its enabled flags were cleared");

    busy_length: assert property (@(posedge zero) disable iff (reset)
        $fell(busy) |-> busy_len == BUSY_TICKS)
        else $error("busy did not last the expected number of ticks");

    left_on_strobe: assert property (@(posedge zero) disable iff (reset)
        !$stable(left) |-> sample)
        else $error("left changed outside a sample strobe");

    right_on_strobe: assert property (@(posedge zero) disable iff (reset)
        !$stable(right) |-> sample)
        else $error("right changed outside a sample strobe");

endmodule

bind opm_top opm_chk u_chk (
    .zero      ( zero      ),
    .reset     ( reset     ),
    .cen       ( cen       ),
    .busy      ( busy      ),
    .flag_a    ( flag_a    ),
    .flag_b    ( flag_b    ),
    .irq_n     ( irq_n     ),
    .timer_cfg ( timer_cfg ),
    .sample    ( sample    ),
    .left      ( left      ),
    .right     ( right     )
);

// ==== rtl/opm_top.sv ====
`timescale 1ns/1ns

module opm_top import opm_pkg::*; (
    input  logic      zero,
    input  logic      reset,
    input  logic      cen,
    input  logic      cs_n,
    input  logic      wr_n,
    input  logic      a0,
    input  bus_byte_t din,
    output bus_byte_t dout,
    output logic      ct1,
    output logic      ct2,
    output logic      irq_n,
    output logic      sample,
    output sample_t   left,
    output sample_t   right,
    output dac_t      dac_left,
    output dac_t      dac_right
);

    logic       write;
    logic       busy;
    logic       flag_a;
    logic       flag_b;
    logic       noise;
    timer_cfg_t timer_cfg;
    noise_cfg_t noise_cfg;
    mix_cfg_t   mix_cfg;
    slot_tick_t tick;

    assign write = !cs_n && !wr_n;

    // status byte
    assign dout = {busy, 5'b0, flag_b, flag_a};

    opm_mmr u_mmr (
        .zero      ( zero      ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .write     ( write     ),
        .a0        ( a0        ),
        .din       ( din       ),
        .busy      ( busy      ),
        .ct1       ( ct1       ),
        .ct2       ( ct2       ),
        .timer_cfg ( timer_cfg ),
        .noise_cfg ( noise_cfg ),
        .mix_cfg   ( mix_cfg   ),
        .tick      ( tick      )
    );

    opm_timers u_timers (
        .zero      ( zero      ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .tick      ( tick      ),
        .timer_cfg ( timer_cfg ),
        .flag_a    ( flag_a    ),
        .flag_b    ( flag_b    ),
        .irq_n     ( irq_n     )
    );

    opm_noise u_noise (
        .zero      ( zero      ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .tick      ( tick      ),
        .noise_cfg ( noise_cfg ),
        .noise     ( noise     )
    );

    opm_mixer u_mixer (
        .zero      ( zero         ),
        .reset     ( reset        ),
        .cen       ( cen          ),
        .tick      ( tick         ),
        .mix_cfg   ( mix_cfg      ),
        .ne        ( noise_cfg.ne ),
        .noise     ( noise        ),
        .sample    ( sample       ),
        .left      ( left         ),
        .right     ( right        ),
        .dac_left  ( dac_left     ),
        .dac_right ( dac_right    )
    );

endmodule

// ==== rtl/opm_mixer.sv ====
`timescale 1ns/1ns

module opm_mixer import opm_pkg::*; (
    input  logic       zero,
    input  logic       reset,
    input  logic       cen,
    input  slot_tick_t tick,
    input  mix_cfg_t   mix_cfg,
    input  logic       ne,
    input  logic       noise,
    output logic       sample,
    output sample_t    left,
    output sample_t    right,
    output dac_t       dac_left,
    output dac_t       dac_right
);

    sample_t mag;
    sample_t noise_val;
    sample_t left_next;
    sample_t right_next;

    assign mag       = sample_t'({2'b00, mix_cfg.level, 6'd0});    // level * 64
    assign noise_val = noise ? mag : -mag;
    assign left_next  = (ne && mix_cfg.pan_left)  ? noise_val : '0;
    assign right_next = (ne && mix_cfg.pan_right) ? noise_val : '0;

    always_ff @(posedge zero) begin
        if (reset) begin
            sample <= 1'b0;
            left   <= '0;
            right  <= '0;
        end else if (cen) begin
            sample <= tick.frame_start;    // marks the new pair
            if (tick.frame_start) begin
                left  <= left_next;
                right <= right_next;
            end
        end
    end

    // sign flip gives offset binary
    assign dac_left  = {~left[15],  left[14:0]};
    assign dac_right = {~right[15], right[14:0]};

endmodule

// ==== rtl/opm_noise.sv ====
`timescale 1ns/1ns

module opm_noise import opm_pkg::*; (
    input  logic       zero,
    input  logic       reset,
    input  logic       cen,
    input  slot_tick_t tick,
    input  noise_cfg_t noise_cfg,
    output logic       noise
);

    logic [16:0] lfsr;
    nfrq_t       period_cnt;    // frames since last shift
    logic        period_end;

    // higher nfrq gives a shorter period
    assign period_end = (period_cnt == (nfrq_t'(31) - noise_cfg.nfrq));

    // stepping mid frame keeps the bit stable at frame_start
    always_ff @(posedge zero) begin
        if (reset) begin
            lfsr       <= NOISE_SEED;
            period_cnt <= '0;
        end else if (cen) begin
            if (!noise_cfg.ne) begin
                lfsr       <= NOISE_SEED;
                period_cnt <= '0;
            end else if (tick.half) begin
                if (period_end) begin
                    period_cnt <= '0;
                    lfsr       <= {lfsr[0] ^ lfsr[3], lfsr[16:1]};
                end else begin
                    period_cnt <= period_cnt + 1'b1;
                end
            end
        end
    end

    assign noise = lfsr[0];

endmodule

// ==== rtl/opm_timers.sv ====
`timescale 1ns/1ns

module opm_timers import opm_pkg::*; (
    input  logic       zero,
    input  logic       reset,
    input  logic       cen,
    input  slot_tick_t tick,
    input  timer_cfg_t timer_cfg,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    timer_a_t   cnt_a;
    timer_b_t   cnt_b;
    logic [3:0] presc_b;      // 16 frames per timer B step
    logic       load_a_d;
    logic       load_b_d;
    logic       start_a;
    logic       start_b;
    logic       step_b;
    logic       over_a;
    logic       over_b;

    // a rising load bit restarts the count from the programmed value
    assign start_a = timer_cfg.load_a && !load_a_d;
    assign start_b = timer_cfg.load_b && !load_b_d;
    assign step_b  = tick.frame_start && (presc_b == '1);

    assign over_a = timer_cfg.load_a && !start_a && tick.frame_start && (cnt_a == '1);
    assign over_b = timer_cfg.load_b && !start_b && step_b && (cnt_b == '1);

    always_ff @(posedge zero) begin
        if (reset) begin
            load_a_d <= 1'b0;
            load_b_d <= 1'b0;
            presc_b  <= '0;
            cnt_a    <= '0;
            cnt_b    <= '0;
        end else if (cen) begin
            load_a_d <= timer_cfg.load_a;
            load_b_d <= timer_cfg.load_b;
            if (tick.frame_start)
                presc_b <= presc_b + 1'b1;    // free running

            if (start_a || over_a)
                cnt_a <= timer_cfg.value_a;
            else if (timer_cfg.load_a && tick.frame_start)
                cnt_a <= cnt_a + 1'b1;

            if (start_b || over_b)
                cnt_b <= timer_cfg.value_b;
            else if (timer_cfg.load_b && step_b)
                cnt_b <= cnt_b + 1'b1;
        end
    end

    // clear pulse beats an overflow on the same tick
    always_ff @(posedge zero) begin
        if (reset) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else if (cen) begin
            if (timer_cfg.clr_a)
                flag_a <= 1'b0;
            else if (over_a)
                flag_a <= 1'b1;

            if (timer_cfg.clr_b)
                flag_b <= 1'b0;
            else if (over_b)
                flag_b <= 1'b1;
        end
    end

    assign irq_n = ~((flag_a && timer_cfg.irq_en_a) || (flag_b && timer_cfg.irq_en_b));

endmodule

// ==== rtl/opm_mmr.sv ====
`timescale 1ns/1ns

module opm_mmr import opm_pkg::*; (
    input  logic       zero,
    input  logic       reset,
    input  logic       cen,
    input  logic       write,
    input  logic       a0,
    input  bus_byte_t  din,
    output logic       busy,
    output logic       ct1,
    output logic       ct2,
    output timer_cfg_t timer_cfg,
    output noise_cfg_t noise_cfg,
    output mix_cfg_t   mix_cfg,
    output slot_tick_t tick
);

    bus_byte_t             addr;
    busy_state_t           state;
    logic [BUSY_CNT_W-1:0] busy_cnt;
    slot_t                 cycles;
    logic                  data_wr;

    // data writes are dropped while busy
    assign data_wr = cen && write && a0 && (state == BUSY_IDLE);
    assign busy    = (state == BUSY_WAIT);

    // slot sequencer, one frame every SLOTS ticks
    always_ff @(posedge zero) begin
        if (reset) begin
            cycles <= '0;
        end else if (cen) begin
            if (cycles == slot_t'(SLOTS - 1))
                cycles <= '0;
            else
                cycles <= cycles + 1'b1;
        end
    end

    assign tick.cycles      = cycles;
    assign tick.frame_start = (cycles == '0);
    assign tick.half        = (cycles == slot_t'(SLOTS / 2));

    // address latch
    always_ff @(posedge zero) begin
        if (reset) begin
            addr <= '0;
        end else if (cen && write && !a0) begin
            addr <= din;
        end
    end

    // busy FSM
    always_ff @(posedge zero) begin
        if (reset) begin
            state    <= BUSY_IDLE;
            busy_cnt <= '0;
        end else if (cen) begin
            case (state)
                BUSY_IDLE: begin
                    if (data_wr) begin
                        state    <= BUSY_WAIT;
                        busy_cnt <= '0;
                    end
                end
                BUSY_WAIT: begin
                    if (busy_cnt == BUSY_CNT_W'(BUSY_TICKS - 1))
                        state <= BUSY_IDLE;
                    else
                        busy_cnt <= busy_cnt + 1'b1;
                end
                default: state <= BUSY_IDLE;
            endcase
        end
    end

    // register storage
    always_ff @(posedge zero) begin
        if (reset) begin
            timer_cfg <= '0;
            noise_cfg <= '0;
            mix_cfg   <= '0;
            ct1       <= 1'b0;
            ct2       <= 1'b0;
        end else if (cen) begin
            timer_cfg.clr_a <= 1'b0;    // clear pulses last one tick
            timer_cfg.clr_b <= 1'b0;
            if (data_wr) begin
                case (addr)
                    ADDR_NOISE: begin
                        noise_cfg.ne   <= din[7];
                        noise_cfg.nfrq <= din[4:0];
                    end
                    ADDR_TA_HI: timer_cfg.value_a[9:2] <= din;
                    ADDR_TA_LO: timer_cfg.value_a[1:0] <= din[1:0];
                    ADDR_TB:    timer_cfg.value_b      <= din;
                    ADDR_TIMER_CTRL: begin
                        timer_cfg.load_a   <= din[0];
                        timer_cfg.load_b   <= din[1];
                        timer_cfg.irq_en_a <= din[2];
                        timer_cfg.irq_en_b <= din[3];
                        timer_cfg.clr_a    <= din[4];
                        timer_cfg.clr_b    <= din[5];
                    end
                    ADDR_LEVEL: mix_cfg.level <= din;
                    ADDR_CT: begin
                        ct1 <= din[6];
                        ct2 <= din[7];
                    end
                    ADDR_PAN: begin
                        mix_cfg.pan_left  <= din[6];
                        mix_cfg.pan_right <= din[7];
                    end
                    default: ;    // unmapped
                endcase
            end
        end
    end

endmodule

// ==== rtl/opm_pkg.sv ====
package opm_pkg;

    // bus and datapath widths
    typedef logic [7:0]         bus_byte_t;    // bus or register byte
    typedef logic [4:0]         slot_t;
    typedef logic [9:0]         timer_a_t;
    typedef logic [7:0]         timer_b_t;
    typedef logic [4:0]         nfrq_t;
    typedef logic signed [15:0] sample_t;
    typedef logic [15:0]        dac_t;         // offset binary

    localparam int SLOTS        = 32;          // slot cycles per frame
    localparam int BUSY_TICKS   = 64;
    localparam int BUSY_CNT_W   = $clog2(BUSY_TICKS);
    localparam logic [16:0] NOISE_SEED = 17'h0_0001;

    // register map
    localparam bus_byte_t ADDR_NOISE      = 8'h0F;  // ne, nfrq
    localparam bus_byte_t ADDR_TA_HI      = 8'h10;  // timer A 9..2
    localparam bus_byte_t ADDR_TA_LO      = 8'h11;  // timer A 1..0
    localparam bus_byte_t ADDR_TB         = 8'h12;
    localparam bus_byte_t ADDR_TIMER_CTRL = 8'h14;
    localparam bus_byte_t ADDR_LEVEL      = 8'h19;
    localparam bus_byte_t ADDR_CT         = 8'h1B;  // bit6 ct1, bit7 ct2
    localparam bus_byte_t ADDR_PAN        = 8'h20;  // bit6 left, bit7 right

    typedef enum logic {
        BUSY_IDLE,
        BUSY_WAIT
    } busy_state_t;

    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;      // run while set
        logic     load_b;
        logic     irq_en_a;
        logic     irq_en_b;
        logic     clr_a;       // one tick
        logic     clr_b;
    } timer_cfg_t;

    typedef struct packed {
        logic  ne;
        nfrq_t nfrq;
    } noise_cfg_t;

    typedef struct packed {
        bus_byte_t level;
        logic      pan_left;
        logic      pan_right;
    } mix_cfg_t;

    typedef struct packed {
        slot_t cycles;
        logic  frame_start;    // cycles == 0
        logic  half;           // cycles == 16
    } slot_tick_t;

endpackage
